//--- common/core_defines.svh
// core sizing macros; QUEUE_DEPTH must be at least 2 and the core is rv32 only

`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// register index width and architectural register count
`define REG_IDX_W 5
`define NUM_REGS 32

// micro-op queue entries
`define QUEUE_DEPTH 4

// datapath width
`define XLEN 32

// fall-through and link distance, no compressed ops
`define INSN_BYTES 4

`endif

//--- common/core_pkg.sv
// op and bundle types of the back end; register and data widths come from core_defines.svh

`include "core_defines.svh"

package core_pkg;

    // one code per alu function or branch type
    typedef enum logic [3:0] {
        fn_add,
        fn_sub,
        fn_and,
        fn_or,
        fn_xor,
        fn_slt,
        fn_sltu,
        fn_beq,
        fn_bne,
        fn_blt,
        fn_bge,
        fn_bltu,
        fn_bgeu,
        fn_jalr
    } uop_fn_e;

    typedef enum logic {
        exu_alu,
        exu_bru
    } exu_e;

    // decoded op as pushed into the queue
    typedef struct packed {
        uop_fn_e                fn;
        exu_e                   exu;
        logic                   use_imm;
        logic                   has_rd;
        logic                   has_rs1;
        logic                   has_rs2;
        logic [`REG_IDX_W-1:0]  rd;
        logic [`REG_IDX_W-1:0]  rs1;
        logic [`REG_IDX_W-1:0]  rs2;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       pc;
        logic                   pred_taken;
    } uop_t;

    // operands read, op held in execute
    typedef struct packed {
        logic                   valid;
        uop_fn_e                fn;
        exu_e                   exu;
        logic                   wb_en;
        logic [`REG_IDX_W-1:0]  rd;
        logic [`XLEN-1:0]       opr1;
        logic [`XLEN-1:0]       opr2;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       pc;
        logic                   pred_taken;
    } issue_t;

    typedef struct packed {
        logic                   valid;
        logic [`REG_IDX_W-1:0]  rd;
        logic [`XLEN-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
    } redirect_t;

endpackage

//--- hw/uop_queue.sv
// micro-op fifo; a push while full and a pop while empty are dropped, flush wins over push

`timescale 1ns/1ps

`include "core_defines.svh"

module uop_queue (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  logic            push,
    input  core_pkg::uop_t  din,
    input  logic            pop,
    output core_pkg::uop_t  head,
    output logic            empty,
    output logic            full
);

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);

    core_pkg::uop_t mem [`QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign empty   = (count == '0);
    assign full    = (count == (PTR_W+1)'(`QUEUE_DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];

    // entry storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                // explicit wrap keeps odd depths working
                wr_ptr <= (wr_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- issue/scoreboard.sv
// pending bit per register; x0 is never marked, a writeback clear beats a same-cycle set

`timescale 1ns/1ps

`include "core_defines.svh"

module scoreboard (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  core_pkg::uop_t  check,
    input  logic            issue,
    input  core_pkg::wb_t   wb,
    output logic            ready
);

    logic [`NUM_REGS-1:0]  pending;
    logic [`REG_IDX_W-1:0] set_idx;
    logic                  set_en;
    logic                  busy_rs1;
    logic                  busy_rs2;
    logic                  busy_rd;

    assign busy_rs1 = check.has_rs1 && pending[check.rs1];
    assign busy_rs2 = check.has_rs2 && pending[check.rs2];
    // waiting on rd too keeps writebacks to one register in order
    assign busy_rd  = check.has_rd && pending[check.rd];
    assign ready    = !(busy_rs1 || busy_rs2 || busy_rd);

    assign set_idx = check.rd;
    assign set_en  = issue && !flush && check.has_rd && (set_idx != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            if (set_en) begin
                pending[set_idx] <= 1'b1;
            end
            // clear after set
            if (wb.valid) begin
                pending[wb.rd] <= 1'b0;
            end
        end
    end

endmodule

//--- issue/issue_stage.sv
// register read and single issue; no bypass, a dependent op waits until its source is written

`timescale 1ns/1ps

`include "core_defines.svh"

module issue_stage (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::uop_t      head,
    input  logic                empty,
    input  core_pkg::redirect_t redirect,
    input  core_pkg::wb_t       wb,
    output logic                pop,
    output core_pkg::issue_t    iss
);

    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic             ready;
    core_pkg::issue_t iss_d;

    scoreboard i_scoreboard (
        .clk   (clk),
        .rst   (rst),
        .flush (redirect.valid),
        .check (head),
        .issue (pop),
        .wb    (wb),
        .ready (ready)
    );

    // architectural state starts at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // x0 reads as zero
    assign rs1_val = (head.rs1 == '0) ? '0 : regs[head.rs1];
    assign rs2_val = (head.rs2 == '0) ? '0 : regs[head.rs2];

    assign pop = !empty && ready;

    always_comb begin
        iss_d.valid      = pop;
        iss_d.fn         = head.fn;
        iss_d.exu        = head.exu;
        iss_d.wb_en      = head.has_rd && (head.rd != '0);
        iss_d.rd         = head.rd;
        iss_d.opr1       = rs1_val;
        iss_d.opr2       = head.use_imm ? head.imm : rs2_val;
        iss_d.imm        = head.imm;
        iss_d.pc         = head.pc;
        iss_d.pred_taken = head.pred_taken;
    end

    // payload loads every cycle, only valid is reset or killed
    always_ff @(posedge clk) begin
        iss <= iss_d;
        if (rst || redirect.valid) begin
            iss.valid <= 1'b0;
        end
    end

endmodule

//--- exec/exec_stage.sv
// one-cycle alu and branch unit; redirect is combinational, wb is registered

`timescale 1ns/1ps

`include "core_defines.svh"

module exec_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  core_pkg::issue_t     iss,
    output core_pkg::wb_t        wb,
    output core_pkg::redirect_t  redirect
);

    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] link;
    logic [`XLEN-1:0] jump_tgt;
    logic [`XLEN-1:0] result;
    logic             eq;
    logic             lt;
    logic             ltu;
    logic             taken;

    always_comb begin
        case (iss.fn)
            core_pkg::fn_add:  alu_res = iss.opr1 + iss.opr2;
            core_pkg::fn_sub:  alu_res = iss.opr1 - iss.opr2;
            core_pkg::fn_and:  alu_res = iss.opr1 & iss.opr2;
            core_pkg::fn_or:   alu_res = iss.opr1 | iss.opr2;
            core_pkg::fn_xor:  alu_res = iss.opr1 ^ iss.opr2;
            core_pkg::fn_slt:  alu_res = {{(`XLEN-1){1'b0}}, lt};
            core_pkg::fn_sltu: alu_res = {{(`XLEN-1){1'b0}}, ltu};
            default:           alu_res = '0;
        endcase
    end

    // shared compare for slt and branches
    assign eq  = (iss.opr1 == iss.opr2);
    assign lt  = ($signed(iss.opr1) < $signed(iss.opr2));
    assign ltu = (iss.opr1 < iss.opr2);

    always_comb begin
        case (iss.fn)
            core_pkg::fn_beq:  taken = eq;
            core_pkg::fn_bne:  taken = !eq;
            core_pkg::fn_blt:  taken = lt;
            core_pkg::fn_bge:  taken = !lt;
            core_pkg::fn_bltu: taken = ltu;
            core_pkg::fn_bgeu: taken = !ltu;
            core_pkg::fn_jalr: taken = 1'b1;
            default:           taken = 1'b0;
        endcase
    end

    assign link = iss.pc + `XLEN'(`INSN_BYTES);

    // jalr is register relative, branches pc relative
    assign jump_tgt = (iss.fn == core_pkg::fn_jalr) ? iss.opr1 + iss.imm : iss.pc + iss.imm;

    assign redirect.valid = iss.valid && (iss.exu == core_pkg::exu_bru)
                            && (taken != iss.pred_taken);
    assign redirect.pc    = taken ? jump_tgt : link;

    // branch unit writes the link value
    assign result = (iss.exu == core_pkg::exu_bru) ? link : alu_res;

    always_ff @(posedge clk) begin
        wb.rd   <= iss.rd;
        wb.data <= result;
        if (rst) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= iss.valid && iss.wb_en;
        end
    end

endmodule

//--- hw/mini_core.sv
// back-end top; push must not be raised while full, redirect flushes queue and issue

`timescale 1ns/1ps

module mini_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  core_pkg::uop_t      uop,
    output logic                full,
    output core_pkg::wb_t       wb,
    output core_pkg::redirect_t redirect
);

    core_pkg::uop_t   head;
    logic             empty;
    logic             pop;
    core_pkg::issue_t iss;

    uop_queue i_uop_queue (
        .clk   (clk),
        .rst   (rst),
        .flush (redirect.valid),
        .push  (push),
        .din   (uop),
        .pop   (pop),
        .head  (head),
        .empty (empty),
        .full  (full)
    );

    issue_stage i_issue_stage (
        .clk      (clk),
        .rst      (rst),
        .head     (head),
        .empty    (empty),
        .redirect (redirect),
        .wb       (wb),
        .pop      (pop),
        .iss      (iss)
    );

    exec_stage i_exec_stage (
        .clk      (clk),
        .rst      (rst),
        .iss      (iss),
        .wb       (wb),
        .redirect (redirect)
    );

endmodule

//--- verif/mini_core_assert.sv
// output-side checks only; queue occupancy is watched through the push and full pins

`timescale 1ns/1ps

module mini_core_assert (
    input logic                clk,
    input logic                rst,
    input logic                push,
    input logic                full,
    input core_pkg::wb_t       wb,
    input core_pkg::redirect_t redirect
);

    // a push while full would be dropped and the op lost
    no_overflow: assert property (@(posedge clk) disable iff (rst) !(push && full))
        else $error("push raised while the queue is full");

    wb_not_x0: assert property (@(posedge clk) disable iff (rst) wb.valid |-> wb.rd != '0)
        else $error("writeback strobe carries register 0");

    // flush kills the op behind the branch
    single_redirect: assert property (@(posedge clk) disable iff (rst)
                                      redirect.valid |=> !redirect.valid)
        else $error("redirect held for two cycles in a row");

endmodule

bind mini_core mini_core_assert i_mini_core_assert (
    .clk      (clk),
    .rst      (rst),
    .push     (push),
    .full     (full),
    .wb       (wb),
    .redirect (redirect)
);

//--- verif/tb_mini_core.sv
// ops are pushed only while full is low and never behind a mispredicted branch before its redirect

`timescale 1ns/1ps

`include "core_defines.svh"

module tb_mini_core;

    typedef struct packed {
        core_pkg::uop_t uop;
        logic           wait_redirect;
    } stim_t;

    logic                clk = 1'b0;
    logic                rst;
    logic                push;
    core_pkg::uop_t      uop;
    logic                full;
    core_pkg::wb_t       wb;
    core_pkg::redirect_t redirect;

    stim_t               stim [$];
    core_pkg::wb_t       exp_wb [$];
    core_pkg::redirect_t exp_redirect [$];
    bit [`XLEN-1:0]      model_regs [`NUM_REGS];
    logic                saw_full = 1'b0;

    mini_core i_mini_core (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .uop      (uop),
        .full     (full),
        .wb       (wb),
        .redirect (redirect)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_wb(input core_pkg::wb_t got, input core_pkg::wb_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: wb x%0d = %h, expected x%0d = %h",
                                $time, got.rd, got.data, exp.rd, exp.data));
        end
    endtask

    task automatic check_redirect(input core_pkg::redirect_t got,
                                  input core_pkg::redirect_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: redirect to %h, expected %h",
                                $time, got.pc, exp.pc));
        end
    endtask

    function automatic core_pkg::uop_t make_uop(core_pkg::uop_fn_e fn, int rd, int rs1,
                                                int rs2, int imm, logic use_imm, logic pred);
        core_pkg::uop_t u;
        u            = '0;
        u.fn         = fn;
        u.exu        = (fn >= core_pkg::fn_beq) ? core_pkg::exu_bru : core_pkg::exu_alu;
        u.use_imm    = use_imm;
        u.has_rd     = (fn < core_pkg::fn_beq) || (fn == core_pkg::fn_jalr);
        u.has_rs1    = 1'b1;
        u.has_rs2    = !use_imm && (fn != core_pkg::fn_jalr);
        u.rd         = `REG_IDX_W'(rd);
        u.rs1        = `REG_IDX_W'(rs1);
        u.rs2        = `REG_IDX_W'(rs2);
        u.imm        = `XLEN'(imm);
        u.pred_taken = pred;
        return u;
    endfunction

    // pc follows the table position
    function automatic void append(core_pkg::uop_t u, logic wait_redirect);
        u.pc = 32'h0000_1000 + `XLEN'(stim.size()) * 4;
        stim.push_back('{u, wait_redirect});
    endfunction

    function automatic void reg_op(core_pkg::uop_fn_e fn, int rd, int rs1, int rs2);
        append(make_uop(fn, rd, rs1, rs2, 0, 1'b0, 1'b0), 1'b0);
    endfunction

    function automatic void imm_op(core_pkg::uop_fn_e fn, int rd, int rs1, int imm);
        append(make_uop(fn, rd, rs1, 0, imm, 1'b1, 1'b0), 1'b0);
    endfunction

    function automatic void branch_op(core_pkg::uop_fn_e fn, int rs1, int rs2, int imm,
                                      logic pred, logic wait_redirect);
        append(make_uop(fn, 0, rs1, rs2, imm, 1'b0, pred), wait_redirect);
    endfunction

    function automatic void build_table();
        core_pkg::uop_t no_rd;
        // independent setup and alu ops
        imm_op(core_pkg::fn_add, 1, 0, 100);
        imm_op(core_pkg::fn_add, 2, 0, -7);
        imm_op(core_pkg::fn_add, 3, 0, 'h5a5);
        imm_op(core_pkg::fn_add, 4, 0, 'h0f0);
        reg_op(core_pkg::fn_sub, 5, 1, 3);
        reg_op(core_pkg::fn_and, 6, 3, 4);
        reg_op(core_pkg::fn_or, 7, 3, 4);
        reg_op(core_pkg::fn_xor, 8, 1, 2);
        reg_op(core_pkg::fn_slt, 9, 2, 1);
        reg_op(core_pkg::fn_sltu, 10, 2, 1);
        imm_op(core_pkg::fn_slt, 11, 1, -1);
        imm_op(core_pkg::fn_sltu, 12, 1, 200);
        // back-to-back dependences
        reg_op(core_pkg::fn_add, 13, 1, 1);
        reg_op(core_pkg::fn_add, 13, 13, 2);
        reg_op(core_pkg::fn_sub, 14, 13, 1);
        // no writeback for x0 or has_rd low
        reg_op(core_pkg::fn_add, 0, 1, 3);
        no_rd        = make_uop(core_pkg::fn_add, 15, 1, 2, 0, 1'b0, 1'b0);
        no_rd.has_rd = 1'b0;
        append(no_rd, 1'b0);
        reg_op(core_pkg::fn_or, 16, 0, 3);
        reg_op(core_pkg::fn_add, 17, 15, 4);
        // correctly predicted branches
        branch_op(core_pkg::fn_beq, 1, 1, 'h20, 1'b1, 1'b0);
        branch_op(core_pkg::fn_bne, 1, 2, 'h20, 1'b1, 1'b0);
        branch_op(core_pkg::fn_blt, 2, 1, 'h20, 1'b1, 1'b0);
        branch_op(core_pkg::fn_bge, 1, 2, 'h20, 1'b1, 1'b0);
        branch_op(core_pkg::fn_bltu, 1, 2, 'h20, 1'b1, 1'b0);
        branch_op(core_pkg::fn_bgeu, 1, 2, 'h20, 1'b0, 1'b0);
        // mispredicted, one each way
        branch_op(core_pkg::fn_beq, 1, 2, 'h40, 1'b1, 1'b1);
        branch_op(core_pkg::fn_bltu, 1, 2, 'h40, 1'b0, 1'b1);
        reg_op(core_pkg::fn_add, 18, 1, 4);
        append(make_uop(core_pkg::fn_jalr, 19, 1, 0, 8, 1'b0, 1'b0), 1'b1);
        append(make_uop(core_pkg::fn_jalr, 20, 1, 0, 0, 1'b0, 1'b1), 1'b0);
        reg_op(core_pkg::fn_add, 21, 19, 0);
        // dependent chain long enough to fill the queue
        for (int k = 0; k < 2 * `QUEUE_DEPTH; k++) begin
            imm_op(core_pkg::fn_add, 22, 22, 1);
        end
        reg_op(core_pkg::fn_sub, 23, 22, 1);
    endfunction

    function automatic void model_op(core_pkg::uop_t u);
        logic [`XLEN-1:0] opr1;
        logic [`XLEN-1:0] opr2;
        logic [`XLEN-1:0] res;
        logic [`XLEN-1:0] target;
        logic             taken;
        opr1   = model_regs[u.rs1];
        opr2   = u.use_imm ? u.imm : model_regs[u.rs2];
        res    = u.pc + 32'd4;
        target = u.pc + u.imm;
        taken  = 1'b0;
        case (u.fn)
            core_pkg::fn_add:  res = opr1 + opr2;
            core_pkg::fn_sub:  res = opr1 - opr2;
            core_pkg::fn_and:  res = opr1 & opr2;
            core_pkg::fn_or:   res = opr1 | opr2;
            core_pkg::fn_xor:  res = opr1 ^ opr2;
            core_pkg::fn_slt:  res = ($signed(opr1) < $signed(opr2)) ? 32'd1 : 32'd0;
            core_pkg::fn_sltu: res = (opr1 < opr2) ? 32'd1 : 32'd0;
            core_pkg::fn_beq:  taken = (opr1 == opr2);
            core_pkg::fn_bne:  taken = (opr1 != opr2);
            core_pkg::fn_blt:  taken = ($signed(opr1) < $signed(opr2));
            core_pkg::fn_bge:  taken = ($signed(opr1) >= $signed(opr2));
            core_pkg::fn_bltu: taken = (opr1 < opr2);
            core_pkg::fn_bgeu: taken = (opr1 >= opr2);
            core_pkg::fn_jalr: begin
                taken  = 1'b1;
                target = opr1 + u.imm;
            end
        endcase
        if (u.has_rd && u.rd != '0) begin
            model_regs[u.rd] = res;
            exp_wb.push_back('{valid: 1'b1, rd: u.rd, data: res});
        end
        if (u.exu == core_pkg::exu_bru && taken != u.pred_taken) begin
            exp_redirect.push_back('{valid: 1'b1, pc: taken ? target : u.pc + 32'd4});
        end
    endfunction

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (full) begin
                saw_full = 1'b1;
            end
            if (wb.valid) begin
                if (exp_wb.size() == 0) begin
                    abort_run($sformatf("unexpected writeback to x%0d at %0t", wb.rd, $time));
                end else begin
                    check_wb(wb, exp_wb.pop_front());
                end
            end
            if (redirect.valid) begin
                if (exp_redirect.size() == 0) begin
                    abort_run($sformatf("unexpected redirect to %h at %0t", redirect.pc, $time));
                end else begin
                    check_redirect(redirect, exp_redirect.pop_front());
                end
            end
        end
    end

    initial begin
        #1;
        repeat (stim.size() * 40 + 100) @(posedge clk);
        abort_run("timeout: the run did not finish in the allowed number of cycles");
    end

    initial begin
        rst  = 1'b1;
        push = 1'b0;
        uop  = '0;
        build_table();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < stim.size(); i++) begin
            while (full) begin
                @(posedge clk);
                #1;
            end
            push = 1'b1;
            uop  = stim[i].uop;
            model_op(stim[i].uop);
            @(posedge clk);
            #1;
            push = 1'b0;
            if (stim[i].wait_redirect) begin
                while (!redirect.valid) begin
                    @(posedge clk);
                    #1;
                end
                // a push at the flush edge would be dropped
                @(posedge clk);
                #1;
            end
        end
        while (exp_wb.size() != 0 || exp_redirect.size() != 0) begin
            @(posedge clk);
        end
        repeat (5) @(posedge clk);
        if (!saw_full) begin
            abort_run("the queue never reported full during the dependent chain");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- tb.f
+incdir+common
common/core_pkg.sv
hw/uop_queue.sv
issue/scoreboard.sv
issue/issue_stage.sv
exec/exec_stage.sv
hw/mini_core.sv
verif/mini_core_assert.sv
verif/tb_mini_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mini_core
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard common/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "no result line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
